// File: design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and register index widths
`define RV_XLEN      32
`define RV_REGA_W    5

// value seen on a read of a register not written since reset
`define RV_RESET_VAL {`RV_XLEN{1'b0}}

// set to 0 to build without the concurrent checks
`define RV_ASSERTS_ON 1

`endif

// File: design/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_R
    } alu_op_e;

    // unit that produces the destination value
    typedef enum logic {
        ZONE_EXE   = 1'b0,
        ZONE_LOADQ = 1'b1
    } zone_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    // imm20 holds imm[20|10:1|11|19:12] as encoded
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_s;

    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        u_fmt_s u_fmt;
        j_fmt_s j_fmt;
    } ins_u;

    typedef struct packed {
        logic                  uerr;
        zone_e                 zone;
        logic                  regd_tgt;
        logic [`RV_REGA_W-1:0] regd_addr;
        logic                  regs1_rd;
        logic [`RV_REGA_W-1:0] regs1_addr;
        logic                  regs2_rd;
        logic [`RV_REGA_W-1:0] regs2_addr;
        logic [`RV_XLEN-1:0]   imm;
        logic                  sels1_pc;
        logic                  sels2_imm;
        logic                  link;
        logic                  jump;
        alu_op_e               alu_op;
        logic [2:0]            funct3;
    } dec_s;

    typedef struct packed {
        logic                  wr;
        logic [`RV_REGA_W-1:0] addr;
        logic [`RV_XLEN-1:0]   data;
    } reg_wr_s;

    typedef struct packed {
        logic [31:0]           ins;
        logic [`RV_XLEN-1:0]   pc;
        logic                  ins_uerr;
        zone_e                 zone;
        logic                  jump;
        logic                  link;
        alu_op_e               alu_op;
        logic [2:0]            funct3;
        logic [`RV_REGA_W-1:0] regd_addr;
        logic [`RV_XLEN-1:0]   operand_left;
        logic [`RV_XLEN-1:0]   operand_right;
        logic [`RV_XLEN-1:0]   regs1_data;
        logic [`RV_XLEN-1:0]   regs2_data;
    } ex_req_s;

endpackage

// File: design/rv_decoder.sv
`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
    input  ins_u ins_i,
    output dec_s dec_o
);

    logic [`RV_XLEN-1:0] imm_i_w;
    logic [`RV_XLEN-1:0] imm_u_w;
    logic [`RV_XLEN-1:0] imm_j_w;
    logic                zero_f7;
    logic                alt_f7;
    logic [2:0]          f3;
    alu_op_e             arith_op;

    // immediates of each format, sign extended
    assign imm_i_w = {{(`RV_XLEN-12){ins_i.i_fmt.imm12[11]}}, ins_i.i_fmt.imm12};
    assign imm_u_w = {ins_i.u_fmt.imm20, 12'h000};
    assign imm_j_w = {{(`RV_XLEN-21){ins_i.j_fmt.imm20[19]}}, ins_i.j_fmt.imm20[19],
                      ins_i.j_fmt.imm20[7:0], ins_i.j_fmt.imm20[8],
                      ins_i.j_fmt.imm20[18:9], 1'b0};

    assign f3      = ins_i.r_fmt.funct3;
    assign zero_f7 = (ins_i.r_fmt.funct7 == 7'b0000000);
    assign alt_f7  = (ins_i.r_fmt.funct7 == 7'b0100000);

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        case (f3)
            3'b000:  arith_op = ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_f7 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_o        = '0;
        dec_o.zone   = ZONE_EXE;
        dec_o.alu_op = ALU_ADD;
        dec_o.funct3 = f3;
        case (ins_i.r_fmt.opcode)
            OPC_OP: begin
                dec_o.regd_tgt = 1'b1;
                dec_o.regs1_rd = 1'b1;
                dec_o.regs2_rd = 1'b1;
                dec_o.alu_op   = (f3 == 3'b000 && alt_f7) ? ALU_SUB : arith_op;
                // only sub and sra take the alternate funct7
                dec_o.uerr     = !(zero_f7 || (alt_f7 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                dec_o.regd_tgt  = 1'b1;
                dec_o.regs1_rd  = 1'b1;
                dec_o.imm       = imm_i_w;
                dec_o.sels2_imm = 1'b1;
                dec_o.alu_op    = arith_op;
                if (f3 == 3'b001) begin
                    dec_o.uerr = !zero_f7;
                end else if (f3 == 3'b101) begin
                    dec_o.uerr = !(zero_f7 || alt_f7);
                end
            end
            OPC_LUI: begin
                dec_o.regd_tgt  = 1'b1;
                dec_o.imm       = imm_u_w;
                dec_o.sels2_imm = 1'b1;
                dec_o.alu_op    = ALU_PASS_R;
                dec_o.funct3    = 3'b000;
            end
            OPC_AUIPC: begin
                dec_o.regd_tgt  = 1'b1;
                dec_o.imm       = imm_u_w;
                dec_o.sels1_pc  = 1'b1;
                dec_o.sels2_imm = 1'b1;
                dec_o.funct3    = 3'b000;
            end
            OPC_JAL: begin
                // execute adds pc and offset for the target
                dec_o.regd_tgt  = 1'b1;
                dec_o.imm       = imm_j_w;
                dec_o.sels1_pc  = 1'b1;
                dec_o.sels2_imm = 1'b1;
                dec_o.jump      = 1'b1;
                dec_o.link      = 1'b1;
                dec_o.funct3    = 3'b000;
            end
            OPC_JALR: begin
                dec_o.regd_tgt  = 1'b1;
                dec_o.regs1_rd  = 1'b1;
                dec_o.imm       = imm_i_w;
                dec_o.sels2_imm = 1'b1;
                dec_o.jump      = 1'b1;
                dec_o.link      = 1'b1;
                dec_o.uerr      = (f3 != 3'b000);
            end
            OPC_LOAD: begin
                dec_o.zone      = ZONE_LOADQ;
                dec_o.regd_tgt  = 1'b1;
                dec_o.regs1_rd  = 1'b1;
                dec_o.imm       = imm_i_w;
                dec_o.sels2_imm = 1'b1;
                dec_o.uerr      = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111);
            end
            default: begin
                dec_o.uerr = 1'b1;
            end
        endcase
        // illegal instructions touch no registers
        if (dec_o.uerr) begin
            dec_o.regd_tgt = 1'b0;
            dec_o.regs1_rd = 1'b0;
            dec_o.regs2_rd = 1'b0;
        end
        // unused register fields read as x0
        dec_o.regd_addr  = dec_o.regd_tgt ? ins_i.r_fmt.rd  : '0;
        dec_o.regs1_addr = dec_o.regs1_rd ? ins_i.r_fmt.rs1 : '0;
        dec_o.regs2_addr = dec_o.regs2_rd ? ins_i.r_fmt.rs2 : '0;
    end

endmodule

// File: design/rv_int_regs.sv
`include "rv_settings.svh"

module rv_int_regs import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  reg_wr_s               wa_i,
    input  reg_wr_s               wb_i,
    input  logic [`RV_REGA_W-1:0] ra_addr_i,
    input  logic [`RV_REGA_W-1:0] rb_addr_i,
    output logic [`RV_XLEN-1:0]   ra_data_o,
    output logic [`RV_XLEN-1:0]   rb_data_o
);

    logic [`RV_XLEN-1:0] regs_q [1:31];
    logic [31:1]         valid_q;
    logic [31:0]         valid_w;
    logic [31:0]         wa_mask;
    logic [31:0]         wb_mask;

    // one-hot of each write, bit 0 is dropped below
    assign wa_mask = wa_i.wr ? (32'd1 << wa_i.addr) : 32'd0;
    assign wb_mask = wb_i.wr ? (32'd1 << wb_i.addr) : 32'd0;

    always_ff @(posedge clk_i) begin
        if (wb_i.wr && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
        // execute port last, so it wins on a shared address
        if (wa_i.wr && wa_i.addr != '0) begin
            regs_q[wa_i.addr] <= wa_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_q | wa_mask[31:1] | wb_mask[31:1];
        end
    end

    // x0 never valid, so reads as the reset value
    assign valid_w   = {valid_q, 1'b0};
    assign ra_data_o = valid_w[ra_addr_i] ? regs_q[ra_addr_i] : `RV_RESET_VAL;
    assign rb_data_o = valid_w[rb_addr_i] ? regs_q[rb_addr_i] : `RV_RESET_VAL;

endmodule

// File: design/rv_load_scoreboard.sv
`include "rv_settings.svh"

module rv_load_scoreboard import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dec_s                  dec_i,
    input  logic                  dav_i,
    input  logic                  accept_i,
    input  logic                  cncl_i,
    input  logic [`RV_REGA_W-1:0] cncl_addr_i,
    input  reg_wr_s               lsq_wb_i,
    output logic                  stall_o
);

    logic [31:1] pend_q;
    logic [31:0] pend_vec;
    logic [31:0] pend_nxt;
    logic        s1_hz;
    logic        s2_hz;
    logic        d_hz;
    logic        mark;
    logic        clr_cncl;
    logic        clr_lsq;

    // bit 0 tied low so x0 never pends
    assign pend_vec = {pend_q, 1'b0};

    // a load-queue write this cycle releases a source read
    assign s1_hz = dec_i.regs1_rd && pend_vec[dec_i.regs1_addr] &&
                   !(lsq_wb_i.wr && lsq_wb_i.addr == dec_i.regs1_addr);
    assign s2_hz = dec_i.regs2_rd && pend_vec[dec_i.regs2_addr] &&
                   !(lsq_wb_i.wr && lsq_wb_i.addr == dec_i.regs2_addr);
    assign d_hz  = dec_i.regd_tgt && pend_vec[dec_i.regd_addr];

    assign stall_o = dav_i && (s1_hz || s2_hz || d_hz);

    assign mark     = accept_i && dec_i.zone == ZONE_LOADQ && dec_i.regd_tgt &&
                      dec_i.regd_addr != '0;
    assign clr_cncl = cncl_i && cncl_addr_i != '0;
    assign clr_lsq  = lsq_wb_i.wr && lsq_wb_i.addr != '0;

    always_comb begin
        pend_nxt = pend_vec;
        if (mark) begin
            pend_nxt[dec_i.regd_addr] = 1'b1;
        end
        if (clr_cncl) begin
            pend_nxt[cncl_addr_i] = 1'b0;
        end
        if (clr_lsq) begin
            pend_nxt[lsq_wb_i.addr] = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_nxt[31:1];
        end
    end

    if (`RV_ASSERTS_ON) begin : g_asserts
        a_mark_free: assert property (@(posedge clk_i) disable iff (reset_i)
            mark |-> !pend_vec[dec_i.regd_addr]);
        a_cncl_pending: assert property (@(posedge clk_i) disable iff (reset_i)
            clr_cncl |-> pend_vec[cncl_addr_i]);
        a_lsq_pending: assert property (@(posedge clk_i) disable iff (reset_i)
            clr_lsq |-> pend_vec[lsq_wb_i.addr]);
        // the pipe must honour the stall when it acknowledges
        a_no_hazard_accept: assert property (@(posedge clk_i) disable iff (reset_i)
            accept_i |-> !(s1_hz || s2_hz || d_hz));
    end

endmodule

// File: design/rv_id_pipe.sv
`include "rv_settings.svh"

module rv_id_pipe import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  pfu_dav_i,
    input  logic [31:0]           pfu_ins_i,
    input  logic [`RV_XLEN-1:0]   pfu_pc_i,
    input  dec_s                  dec_i,
    input  logic                  stall_i,
    output logic                  pfu_ack_o,
    output logic                  accept_o,
    output logic [`RV_REGA_W-1:0] rs1_addr_o,
    output logic [`RV_REGA_W-1:0] rs2_addr_o,
    input  logic [`RV_XLEN-1:0]   rs1_data_i,
    input  logic [`RV_XLEN-1:0]   rs2_data_i,
    input  reg_wr_s               exs_wb_i,
    input  reg_wr_s               lsq_wb_i,
    input  logic                  exs_stall_i,
    output logic                  exs_valid_o,
    output ex_req_s               exs_req_o
);

    logic                exe_hold;
    logic                valid_q;
    logic [31:0]         ins_q;
    logic [`RV_XLEN-1:0] pc_q;
    dec_s                dec_q;
    logic [`RV_XLEN-1:0] rs1_fwd;
    logic [`RV_XLEN-1:0] rs2_fwd;

    // execute has priority over the load queue and x0 is never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_sel(
        input logic [`RV_REGA_W-1:0] addr,
        input logic [`RV_XLEN-1:0]   rf_data,
        input reg_wr_s               exs_wb,
        input reg_wr_s               lsq_wb
    );
        logic [`RV_XLEN-1:0] res;
        res = rf_data;
        if (addr != '0) begin
            if (exs_wb.wr && exs_wb.addr == addr) begin
                res = exs_wb.data;
            end else if (lsq_wb.wr && lsq_wb.addr == addr) begin
                res = lsq_wb.data;
            end
        end
        return res;
    endfunction

    // execute holding a valid packet blocks acceptance
    assign exe_hold  = exs_stall_i && valid_q;
    assign pfu_ack_o = pfu_dav_i && !stall_i && !exe_hold;
    assign accept_o  = pfu_ack_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (pfu_ack_o) begin
            valid_q <= 1'b1;
        end else if (!exe_hold) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pfu_ack_o) begin
            ins_q <= pfu_ins_i;
            pc_q  <= pfu_pc_i;
            dec_q <= dec_i;
        end
    end

    // file is read at the registered addresses
    assign rs1_addr_o = dec_q.regs1_addr;
    assign rs2_addr_o = dec_q.regs2_addr;

    assign rs1_fwd = fwd_sel(dec_q.regs1_addr, rs1_data_i, exs_wb_i, lsq_wb_i);
    assign rs2_fwd = fwd_sel(dec_q.regs2_addr, rs2_data_i, exs_wb_i, lsq_wb_i);

    assign exs_valid_o = valid_q;

    always_comb begin
        exs_req_o.ins           = ins_q;
        exs_req_o.pc            = pc_q;
        exs_req_o.ins_uerr      = dec_q.uerr;
        exs_req_o.zone          = dec_q.zone;
        exs_req_o.jump          = dec_q.jump;
        exs_req_o.link          = dec_q.link;
        exs_req_o.alu_op        = dec_q.alu_op;
        exs_req_o.funct3        = dec_q.funct3;
        exs_req_o.regd_addr     = dec_q.regd_addr;
        exs_req_o.operand_left  = dec_q.sels1_pc ? pc_q : rs1_fwd;
        exs_req_o.operand_right = dec_q.sels2_imm ? dec_q.imm : rs2_fwd;
        exs_req_o.regs1_data    = rs1_fwd;
        exs_req_o.regs2_data    = rs2_fwd;
    end

endmodule

// File: design/rv_decode_unit.sv
`include "rv_settings.svh"

module rv_decode_unit import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    // prefetch side
    input  logic                pfu_dav_i,
    output logic                pfu_ack_o,
    input  logic [31:0]         pfu_ins_i,
    input  logic [`RV_XLEN-1:0] pfu_pc_i,
    // execute side
    output logic                exs_valid_o,
    input  logic                exs_stall_i,
    output ex_req_s             exs_req_o,
    // write-back
    input  reg_wr_s             exs_wb_i,
    input  logic                exs_cncl_load_i,
    input  reg_wr_s             lsq_wb_i
);

    dec_s                  dec;
    logic                  sb_stall;
    logic                  accept;
    logic [`RV_REGA_W-1:0] rs1_addr;
    logic [`RV_REGA_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    rv_decoder u_decoder (
        .ins_i (pfu_ins_i),
        .dec_o (dec)
    );

    // pending loads, cancel address rides on the execute write port
    rv_load_scoreboard u_scoreboard (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .dec_i       (dec),
        .dav_i       (pfu_dav_i),
        .accept_i    (accept),
        .cncl_i      (exs_cncl_load_i),
        .cncl_addr_i (exs_wb_i.addr),
        .lsq_wb_i    (lsq_wb_i),
        .stall_o     (sb_stall)
    );

    rv_int_regs u_int_regs (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wa_i      (exs_wb_i),
        .wb_i      (lsq_wb_i),
        .ra_addr_i (rs1_addr),
        .rb_addr_i (rs2_addr),
        .ra_data_o (rs1_data),
        .rb_data_o (rs2_data)
    );

    rv_id_pipe u_id_pipe (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pfu_dav_i   (pfu_dav_i),
        .pfu_ins_i   (pfu_ins_i),
        .pfu_pc_i    (pfu_pc_i),
        .dec_i       (dec),
        .stall_i     (sb_stall),
        .pfu_ack_o   (pfu_ack_o),
        .accept_o    (accept),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .exs_wb_i    (exs_wb_i),
        .lsq_wb_i    (lsq_wb_i),
        .exs_stall_i (exs_stall_i),
        .exs_valid_o (exs_valid_o),
        .exs_req_o   (exs_req_o)
    );

endmodule

// File: dv/tb_decode_unit.sv
module tb_decode_unit import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 4000;

    typedef struct packed {
        logic [31:0] ins;
        logic [31:0] pc;
    } fetch_s;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        pfu_dav_i;
    logic        pfu_ack_o;
    logic [31:0] pfu_ins_i;
    logic [31:0] pfu_pc_i;
    logic        exs_valid_o;
    logic        exs_stall_i;
    ex_req_s     exs_req_o;
    reg_wr_s     exs_wb_i;
    logic        exs_cncl_load_i;
    reg_wr_s     lsq_wb_i;

    integer      seed = 32'h95944aed;
    integer      cycles = 0;
    logic [31:0] shadow [0:31];
    fetch_s      sent_q [$];
    ex_req_s     held;
    logic [31:0] ins;
    logic [31:0] w;

    rv_decode_unit DUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic alu_op_e arith_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // register value as execute sees it with same-cycle writes included
    function automatic logic [31:0] read_operand(input logic [4:0] a, input reg_wr_s ew,
                                                 input reg_wr_s lw);
        if (a == 5'd0) return 32'd0;
        if (ew.wr && ew.addr == a) return ew.data;
        if (lw.wr && lw.addr == a) return lw.data;
        return shadow[a];
    endfunction

    function automatic ex_req_s ref_req(input logic [31:0] i, input logic [31:0] pc,
                                        input reg_wr_s ew, input reg_wr_s lw);
        ex_req_s     r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        rd_en;
        logic        s1_en;
        logic        s2_en;
        logic        sel_pc;
        logic        sel_imm;
        logic        bad;
        logic [31:0] imm;
        logic [31:0] d1;
        logic [31:0] d2;
        r = '0;
        f3 = i[14:12];
        f7 = i[31:25];
        {rd_en, s1_en, s2_en, sel_pc, sel_imm, bad} = '0;
        imm = '0;
        r.ins = i;
        r.pc = pc;
        r.zone = ZONE_EXE;
        r.alu_op = ALU_ADD;
        r.funct3 = f3;
        case (i[6:0])
            7'b0110011: begin
                {rd_en, s1_en, s2_en} = 3'b111;
                r.alu_op = (f3 == 0 && f7 == 7'h20) ? ALU_SUB : arith_alu(f3, f7 == 7'h20);
                bad = !(f7 == 0 || (f7 == 7'h20 && (f3 == 0 || f3 == 5)));
            end
            7'b0010011: begin
                {rd_en, s1_en, sel_imm} = 3'b111;
                imm = {{20{i[31]}}, i[31:20]};
                r.alu_op = arith_alu(f3, f7 == 7'h20);
                if (f3 == 1) bad = (f7 != 0);
                if (f3 == 5) bad = !(f7 == 0 || f7 == 7'h20);
            end
            7'b0110111, 7'b0010111: begin
                {rd_en, sel_imm} = 2'b11;
                sel_pc = i[5] == 1'b0;
                imm = {i[31:12], 12'h000};
                r.alu_op = i[5] ? ALU_PASS_R : ALU_ADD;
                r.funct3 = 3'd0;
            end
            7'b1101111: begin
                {rd_en, sel_pc, sel_imm, r.jump, r.link} = 5'b11111;
                imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
                r.funct3 = 3'd0;
            end
            7'b1100111: begin
                {rd_en, s1_en, sel_imm, r.jump, r.link} = 5'b11111;
                imm = {{20{i[31]}}, i[31:20]};
                bad = (f3 != 0);
            end
            7'b0000011: begin
                {rd_en, s1_en, sel_imm} = 3'b111;
                r.zone = ZONE_LOADQ;
                imm = {{20{i[31]}}, i[31:20]};
                bad = (f3 == 3 || f3 == 6 || f3 == 7);
            end
            default: bad = 1'b1;
        endcase
        if (bad) {rd_en, s1_en, s2_en} = '0;
        r.ins_uerr = bad;
        r.regd_addr = rd_en ? i[11:7] : 5'd0;
        d1 = read_operand(s1_en ? i[19:15] : 5'd0, ew, lw);
        d2 = read_operand(s2_en ? i[24:20] : 5'd0, ew, lw);
        r.regs1_data = d1;
        r.regs2_data = d2;
        r.operand_left = sel_pc ? pc : d1;
        r.operand_right = sel_imm ? imm : d2;
        return r;
    endfunction

    // compares each released packet and records transfers and write-backs
    always @(negedge clk_i) begin
        fetch_s  f;
        ex_req_s e;
        if (!reset_i) begin
            if (!pfu_dav_i) check_val("pfu_ack_o", pfu_ack_o, 1'b0);
            if (exs_valid_o && exs_stall_i) check_val("pfu_ack_o", pfu_ack_o, 1'b0);
            if (exs_valid_o && !exs_stall_i) begin
                if (sent_q.size() == 0) begin
                    $display("valid packet at t=%0t with no accepted instruction", $time);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
                f = sent_q.pop_front();
                e = ref_req(f.ins, f.pc, exs_wb_i, lsq_wb_i);
                check_val("exs_req_o.ins", exs_req_o.ins, e.ins);
                check_val("exs_req_o.pc", exs_req_o.pc, e.pc);
                check_val("exs_req_o.ins_uerr", exs_req_o.ins_uerr, e.ins_uerr);
                check_val("exs_req_o.zone", exs_req_o.zone, e.zone);
                check_val("exs_req_o.jump", exs_req_o.jump, e.jump);
                check_val("exs_req_o.link", exs_req_o.link, e.link);
                check_val("exs_req_o.alu_op", exs_req_o.alu_op, e.alu_op);
                check_val("exs_req_o.funct3", exs_req_o.funct3, e.funct3);
                check_val("exs_req_o.regd_addr", exs_req_o.regd_addr, e.regd_addr);
                check_val("exs_req_o.operand_left", exs_req_o.operand_left, e.operand_left);
                check_val("exs_req_o.operand_right", exs_req_o.operand_right,
                          e.operand_right);
                check_val("exs_req_o.regs1_data", exs_req_o.regs1_data, e.regs1_data);
                check_val("exs_req_o.regs2_data", exs_req_o.regs2_data, e.regs2_data);
            end
            if (pfu_dav_i && pfu_ack_o) sent_q.push_back({pfu_ins_i, pfu_pc_i});
            if (lsq_wb_i.wr && lsq_wb_i.addr != 0) shadow[lsq_wb_i.addr] = lsq_wb_i.data;
            if (exs_wb_i.wr && exs_wb_i.addr != 0) shadow[exs_wb_i.addr] = exs_wb_i.data;
        end
    end

    // called just after a rising edge and returns just after the transfer edge
    task automatic send_ins(input logic [31:0] i);
        pfu_dav_i = 1'b1;
        pfu_ins_i = i;
        pfu_pc_i = $random(seed) & 32'hffff_fffc;
        do @(negedge clk_i); while (!pfu_ack_o);
        @(posedge clk_i);
        #1;
        pfu_dav_i = 1'b0;
    endtask

    task automatic drive_wb(input logic ew, input logic [4:0] ea, input logic lw,
                            input logic [4:0] la);
        exs_wb_i = {ew, ea, 32'($random(seed))};
        lsq_wb_i = {lw, la, 32'($random(seed))};
        @(posedge clk_i);
        #1;
        exs_wb_i = '0;
        lsq_wb_i = '0;
    endtask

    task automatic expect_blocked(input int n);
        repeat (n) begin
            @(negedge clk_i);
            check_val("pfu_ack_o", pfu_ack_o, 1'b0);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic gen_ins(output logic [31:0] i);
        logic [31:0] r;
        int          sel;
        r = $random(seed);
        sel = ($random(seed) & 32'h7fff_ffff) % 6;
        i = r;
        case (sel)
            0: begin
                i[31:25] = ((r[14:12] == 0 || r[14:12] == 5) && r[30]) ? 7'h20 : 7'h00;
                i[6:0] = OPC_OP;
            end
            1: begin
                if (r[14:12] == 1) i[31:25] = 7'h00;
                if (r[14:12] == 5) i[31:25] = r[30] ? 7'h20 : 7'h00;
                i[6:0] = OPC_OP_IMM;
            end
            2: i[6:0] = OPC_LUI;
            3: i[6:0] = OPC_AUIPC;
            4: i[6:0] = OPC_JAL;
            default: begin
                i[14:12] = 3'd0;
                i[6:0] = OPC_JALR;
            end
        endcase
    endtask

    initial begin
        // a load to x16 offered during reset must leave no packet and no pending mark
        reset_i = 1'b1;
        pfu_dav_i = 1'b1;
        pfu_ins_i = {12'h000, 5'd1, 3'b010, 5'd16, OPC_LOAD};
        pfu_pc_i = '0;
        exs_stall_i = 1'b0;
        exs_wb_i = '0;
        exs_cncl_load_i = 1'b0;
        lsq_wb_i = '0;
        for (int k = 0; k < 32; k++) shadow[k] = 32'd0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        pfu_dav_i = 1'b0;
        repeat (3) begin
            @(negedge clk_i);
            check_val("exs_valid_o", exs_valid_o, 1'b0);
        end
        @(posedge clk_i);
        #1;
        // low half through execute and high half through loads
        for (int r = 1; r < 16; r++) drive_wb(1'b1, 5'(r), 1'b0, 5'd0);
        for (int r = 16; r < 32; r++) begin
            w = $random(seed);
            send_ins({w[31:20], 5'd1, 3'b010, 5'(r), OPC_LOAD});
            drive_wb(1'b0, 5'd0, 1'b1, 5'(r));
        end
        // random traffic with execute write-backs that include x0
        for (int n = 0; n < 300; n++) begin
            gen_ins(ins);
            send_ins(ins);
            w = $random(seed);
            if (w[0]) drive_wb(1'b1, w[5:1], 1'b0, 5'd0);
        end
        // source hazard released by the load-queue write
        send_ins({12'h010, 5'd1, 3'b010, 5'd5, OPC_LOAD});
        pfu_dav_i = 1'b1;
        pfu_ins_i = {7'h00, 5'd7, 5'd5, 3'b000, 5'd6, OPC_OP};
        expect_blocked(3);
        lsq_wb_i = {1'b1, 5'd5, 32'($random(seed))};
        @(negedge clk_i);
        check_val("pfu_ack_o", pfu_ack_o, 1'b1);
        @(posedge clk_i);
        #1;
        pfu_dav_i = 1'b0;
        lsq_wb_i = '0;
        // destination hazard and an execute-side write elsewhere before the cancel
        send_ins({12'h004, 5'd2, 3'b010, 5'd8, OPC_LOAD});
        drive_wb(1'b1, 5'd3, 1'b0, 5'd0);
        pfu_dav_i = 1'b1;
        pfu_ins_i = {12'h001, 5'd4, 3'b000, 5'd8, OPC_OP_IMM};
        expect_blocked(3);
        exs_cncl_load_i = 1'b1;
        exs_wb_i = {1'b0, 5'd8, 32'd0};
        @(posedge clk_i);
        #1;
        exs_cncl_load_i = 1'b0;
        exs_wb_i = '0;
        send_ins(pfu_ins_i);
        // back-pressure on a valid packet
        send_ins({7'h20, 5'd9, 5'd10, 3'b000, 5'd11, OPC_OP});
        exs_stall_i = 1'b1;
        pfu_dav_i = 1'b1;
        pfu_ins_i = {12'h123, 5'd12, 3'b100, 5'd13, OPC_OP_IMM};
        @(negedge clk_i);
        held = exs_req_o;
        repeat (4) begin
            @(negedge clk_i);
            check_val("exs_req_o", exs_req_o, held);
            check_val("exs_valid_o", exs_valid_o, 1'b1);
        end
        @(posedge clk_i);
        #1;
        exs_stall_i = 1'b0;
        send_ins(pfu_ins_i);
        // illegal forms where the bad load leaves x9 free
        send_ins({7'h00, 5'd1, 5'd2, 3'b000, 5'd3, 7'b1110011});
        send_ins({7'h01, 5'd4, 5'd5, 3'b101, 5'd6, OPC_OP});
        send_ins({12'h008, 5'd1, 3'b011, 5'd9, OPC_LOAD});
        send_ins({7'h00, 5'd9, 5'd9, 3'b000, 5'd14, OPC_OP});
        repeat (3) @(posedge clk_i);
        if (sent_q.size() != 0) begin
            $display("%0d accepted instructions never reached execute", sent_q.size());
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tb.f
+incdir+design
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_int_regs.sv
design/rv_load_scoreboard.sv
design/rv_id_pipe.sv
design/rv_decode_unit.sv
dv/tb_decode_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_unit
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
